// File: analog_pkg.sv
`default_nettype none

package analog_pkg;

  //////////////////////////////////////////////////
  // converter widths
  //////////////////////////////////////////////////

  localparam int unsigned ADC_PIN_W = 16;  // raw ADC pin bus per channel
  localparam int unsigned ADC_RSV_W = 2;   // reserved low bits, 16 bit ADC parts only
  localparam int unsigned SAMPLE_W  = 14;  // converter resolution
  localparam int unsigned SUM_W     = 15;  // one guard bit for gen + feedback
  localparam int unsigned PDM_CHN   = 4;   // slow analog outputs
  localparam int unsigned PDM_DWC   = 8;   // pdm level resolution

  typedef logic        [ADC_PIN_W-1:0] adc_pin_t;    // raw pins of one channel
  typedef logic signed [SAMPLE_W-1:0]  sample_t;     // two's complement
  typedef logic signed [SUM_W-1:0]     sum_t;        // before saturation
  typedef logic        [SAMPLE_W-1:0]  dac_code_t;   // offset binary, neg slope
  typedef logic        [PDM_DWC-1:0]   pdm_level_t;

  typedef struct packed {
    adc_pin_t a;  // channel 1
    adc_pin_t b;  // channel 2
  } adc_pins_t;

  typedef struct packed {
    sample_t a;
    sample_t b;
  } sample_pair_t;

  typedef struct packed {
    dac_code_t a;
    dac_code_t b;
  } dac_codes_t;

  typedef pdm_level_t [PDM_CHN-1:0] pdm_cfg_t;  // one level per pdm channel

  // neg slope offset binary <-> two's complement
  // msb stays, the rest is inverted, so both directions are the same flip
  function automatic sample_t code_to_sample(dac_code_t code);
    return sample_t'({code[SAMPLE_W-1], ~code[SAMPLE_W-2:0]});
  endfunction

  function automatic dac_code_t sample_to_code(sample_t smp);
    return dac_code_t'({smp[SAMPLE_W-1], ~smp[SAMPLE_W-2:0]});
  endfunction

endpackage : analog_pkg

`default_nettype wire

// File: adc_frontend.sv
`default_nettype none

module adc_frontend (
  input  logic                    adc_clk,         // adc sample clock
  input  logic                    reset_i,         // sync, active high
  input  analog_pkg::adc_pins_t    adc_pins_i,      // raw pin words, both channels
  input  logic                    digital_loop_i,  // 1 = take dac samples instead
  input  analog_pkg::sample_pair_t loop_i,          // dac bound samples (mixer output)
  output analog_pkg::sample_pair_t adc_o            // signed samples to consumers
);

//////////////////////////////////////////////////
// stage 1: pin capture
//////////////////////////////////////////////////

// only the upper 14 bits carry data, the 2 lsbs are reserved on 16 bit parts
analog_pkg::dac_codes_t pin_q;    // same offset binary format as the dac side
analog_pkg::dac_codes_t pin_d;

assign pin_d.a = adc_pins_i.a[analog_pkg::ADC_PIN_W-1:analog_pkg::ADC_RSV_W];
assign pin_d.b = adc_pins_i.b[analog_pkg::ADC_PIN_W-1:analog_pkg::ADC_RSV_W];

// should map to iob registers
always_ff @(posedge adc_clk)
begin
  if (reset_i)
  begin
    pin_q.a <= analog_pkg::sample_to_code('0);  // code of zero, 0x1fff
    pin_q.b <= analog_pkg::sample_to_code('0);
  end
  else
  begin
    pin_q <= pin_d;
  end
end

//////////////////////////////////////////////////
// stage 2: conversion and loopback select
//////////////////////////////////////////////////

analog_pkg::sample_pair_t conv;   // converted pins
analog_pkg::sample_pair_t adc_d;  // next value of the output register
analog_pkg::sample_pair_t adc_q;

// negative slope offset binary -> two's complement
assign conv.a = analog_pkg::code_to_sample(pin_q.a);
assign conv.b = analog_pkg::code_to_sample(pin_q.b);

// loopback bypasses the pin stage, so both paths are 2 cycles deep
assign adc_d = digital_loop_i ? loop_i : conv;

always_ff @(posedge adc_clk)
begin
  if (reset_i)
  begin
    adc_q <= '0;  // sample zero on both channels
  end
  else
  begin
    adc_q <= adc_d;
  end
end

assign adc_o = adc_q;

endmodule : adc_frontend

`default_nettype wire

// File: dac_mixer.sv
`default_nettype none

module dac_mixer (
  input  logic                    adc_clk,  // shared sample clock
  input  logic                    reset_i,  // sync, active high
  input  analog_pkg::sample_pair_t gen_i,    // generator samples
  input  analog_pkg::sample_pair_t fb_i,     // feedback controller samples
  output analog_pkg::sample_pair_t mix_o     // saturated sum, registered
);

//////////////////////////////////////////////////
// saturation
//////////////////////////////////////////////////

// top two bits differ -> sum left the 14 bit range
// clip to +8191 or -8192 depending on the sign bit
function automatic analog_pkg::sample_t saturate(analog_pkg::sum_t sum);
  analog_pkg::sample_t res;
  if (sum[analog_pkg::SUM_W-1] ^ sum[analog_pkg::SUM_W-2])
  begin
    res = {sum[analog_pkg::SUM_W-1], {(analog_pkg::SAMPLE_W-1){~sum[analog_pkg::SUM_W-1]}}};
  end
  else
  begin
    res = sum[analog_pkg::SAMPLE_W-1:0];  // fits, drop the guard bit
  end
  return res;
endfunction

//////////////////////////////////////////////////
// per channel sum
//////////////////////////////////////////////////

analog_pkg::sum_t         sum_a;   // ch1 widened sum
analog_pkg::sum_t         sum_b;   // ch2 widened sum
analog_pkg::sample_pair_t mix_d;
analog_pkg::sample_pair_t mix_q;

// sign extend both operands before adding, one guard bit is enough
assign sum_a = analog_pkg::sum_t'(gen_i.a) + analog_pkg::sum_t'(fb_i.a);
assign sum_b = analog_pkg::sum_t'(gen_i.b) + analog_pkg::sum_t'(fb_i.b);

assign mix_d.a = saturate(sum_a);
assign mix_d.b = saturate(sum_b);

// one register stage, feeds both the dac formatter and the adc loopback
always_ff @(posedge adc_clk)
begin
  if (reset_i)
  begin
    mix_q <= '0;
  end
  else
  begin
    mix_q <= mix_d;
  end
end

assign mix_o = mix_q;

endmodule : dac_mixer

`default_nettype wire

// File: dac_formatter.sv
`default_nettype none

module dac_formatter (
  input  logic                    adc_clk,      // dac runs on the adc clock here
  input  logic                    reset_i,      // sync, active high
  input  analog_pkg::sample_pair_t mix_i,        // saturated signed samples
  output analog_pkg::dac_codes_t   dac_codes_o,  // parallel codes, one per channel
  output logic                    dac_rst_o     // converter reset level
);

//////////////////////////////////////////////////
// signed -> dac code
//////////////////////////////////////////////////

analog_pkg::dac_codes_t code_d;
analog_pkg::dac_codes_t code_q;
logic                   dac_rst_q;

// the dac wants negative slope offset binary, same flip as the adc side
assign code_d.a = analog_pkg::sample_to_code(mix_i.a);
assign code_d.b = analog_pkg::sample_to_code(mix_i.b);

// output register
always_ff @(posedge adc_clk)
begin
  if (reset_i)
  begin
    code_q.a <= analog_pkg::sample_to_code('0);  // mid scale, 0x1fff
    code_q.b <= analog_pkg::sample_to_code('0);
  end
  else
  begin
    code_q <= code_d;
  end
end

// converter reset follows reset_i one edge late
always_ff @(posedge adc_clk)
begin
  dac_rst_q <= reset_i;
end

assign dac_codes_o = code_q;
assign dac_rst_o   = dac_rst_q;

endmodule : dac_formatter

`default_nettype wire

// File: pdm_modulator.sv
`default_nettype none

module pdm_modulator (
  input  logic                             adc_clk,    // modulator clock
  input  logic                             reset_i,    // sync, active high
  input  analog_pkg::pdm_cfg_t              pdm_cfg_i,  // one 8 bit level per channel
  output logic [analog_pkg::PDM_CHN-1:0]    pdm_o       // 1 bit density outputs
);

//////////////////////////////////////////////////
// first order accumulators
//////////////////////////////////////////////////

// each cycle acc += level, the carry is the output bit
// after 256 cycles of a steady level acc is back where it started
// so exactly level carries were produced

analog_pkg::pdm_cfg_t                 acc_q;                         // accumulators
logic [analog_pkg::PDM_DWC:0]         acc_sum [analog_pkg::PDM_CHN];  // carry + new acc
logic [analog_pkg::PDM_CHN-1:0]       pdm_q;

always_comb
begin
  for (int i = 0; i < analog_pkg::PDM_CHN; i++)
  begin
    acc_sum[i] = {1'b0, acc_q[i]} + {1'b0, pdm_cfg_i[i]};  // 9 bit, msb is carry
  end
end

always_ff @(posedge adc_clk)
begin
  if (reset_i)
  begin
    acc_q <= '0;
    pdm_q <= '0;  // outputs low in reset
  end
  else
  begin
    for (int i = 0; i < analog_pkg::PDM_CHN; i++)
    begin
      acc_q[i] <= acc_sum[i][analog_pkg::PDM_DWC-1:0];  // wrap around
      pdm_q[i] <= acc_sum[i][analog_pkg::PDM_DWC];      // registered carry
    end
  end
end

assign pdm_o = pdm_q;

endmodule : pdm_modulator

`default_nettype wire

// File: analog_top.sv
`default_nettype none

module analog_top (
  input  logic                          adc_clk,         // single clock for everything
  input  logic                          reset_i,         // sync, active high
  // adc
  input  analog_pkg::adc_pins_t          adc_pins_i,      // raw adc pins
  input  logic                          digital_loop_i,  // dac -> adc digital loopback
  output analog_pkg::sample_pair_t       adc_o,           // signed adc samples
  // dac sources
  input  analog_pkg::sample_pair_t       gen_i,           // generator
  input  analog_pkg::sample_pair_t       fb_i,            // feedback controller
  // dac
  output analog_pkg::dac_codes_t         dac_codes_o,     // parallel dac codes
  output logic                          dac_rst_o,       // dac reset
  // slow analog outputs
  input  analog_pkg::pdm_cfg_t           pdm_cfg_i,       // pdm levels
  output logic [analog_pkg::PDM_CHN-1:0] pdm_o            // pdm bit streams
);

// saturated dac samples, also the loopback source
analog_pkg::sample_pair_t mix;

//////////////////////////////////////////////////
// adc side
//////////////////////////////////////////////////

adc_frontend i_frontend (
  .adc_clk        (adc_clk       ),
  .reset_i        (reset_i       ),
  .adc_pins_i     (adc_pins_i    ),
  .digital_loop_i (digital_loop_i),
  .loop_i         (mix           ),  // loopback takes the mixer register
  .adc_o          (adc_o         )
);

//////////////////////////////////////////////////
// dac side
//////////////////////////////////////////////////

dac_mixer i_mixer (
  .adc_clk (adc_clk),
  .reset_i (reset_i),
  .gen_i   (gen_i  ),
  .fb_i    (fb_i   ),
  .mix_o   (mix    )
);

// gen/fb -> codes is 2 cycles, mixer + formatter
dac_formatter i_formatter (
  .adc_clk     (adc_clk    ),
  .reset_i     (reset_i    ),
  .mix_i       (mix        ),
  .dac_codes_o (dac_codes_o),
  .dac_rst_o   (dac_rst_o  )
);

//////////////////////////////////////////////////
// pdm outputs
//////////////////////////////////////////////////

// parallel branch, nothing shared with the sample pipeline
pdm_modulator i_pdm (
  .adc_clk   (adc_clk  ),
  .reset_i   (reset_i  ),
  .pdm_cfg_i (pdm_cfg_i),
  .pdm_o     (pdm_o    )
);

endmodule : analog_top

`default_nettype wire

// File: tb_clock.sv
`default_nettype none

module tb_clock (
  output logic adc_clk_o,  // 125 MHz sample clock
  output logic reset_o     // sync reset, active high
);
  timeunit 1ns;
  timeprecision 100ps;

  initial
  begin
    adc_clk_o = 1'b0;
    forever #4 adc_clk_o = ~adc_clk_o;  // 8 ns period
  end

  // high for 10 rising edges, released on a falling edge
  initial
  begin
    reset_o = 1'b1;
    repeat (10) @(posedge adc_clk_o);
    @(negedge adc_clk_o);
    reset_o = 1'b0;
  end

endmodule : tb_clock

`default_nettype wire

// File: tb_analog_top.sv
`default_nettype none

module tb_analog_top;
  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    analog_pkg::adc_pins_t    pins;
    analog_pkg::sample_pair_t gen;
    analog_pkg::sample_pair_t fb;
  } in_rec_t;  // stream inputs seen at one edge

  typedef struct packed {
    analog_pkg::sample_pair_t adc;
    analog_pkg::dac_codes_t   dac;
  } out_rec_t;

  logic                           adc_clk;
  logic                           reset_i;
  analog_pkg::adc_pins_t          adc_pins_i;
  logic                           digital_loop_i;
  analog_pkg::sample_pair_t       gen_i;
  analog_pkg::sample_pair_t       fb_i;
  analog_pkg::pdm_cfg_t           pdm_cfg_i;
  analog_pkg::sample_pair_t       adc_o;
  analog_pkg::dac_codes_t         dac_codes_o;
  logic                           dac_rst_o;
  logic [analog_pkg::PDM_CHN-1:0] pdm_o;

  int unsigned errors;
  int unsigned checks;
  int unsigned tests_run;
  int unsigned tests_failed;
  int unsigned errors_at_start;  // error count when the current test began
  string       cur_test;
  integer      seed;
  in_rec_t     hist[$];          // delay line with the newest entry first

  tb_clock i_clock (
    .adc_clk_o (adc_clk),
    .reset_o   (reset_i)
  );

  analog_top dut (
    .adc_clk        (adc_clk       ),
    .reset_i        (reset_i       ),
    .adc_pins_i     (adc_pins_i    ),
    .digital_loop_i (digital_loop_i),
    .adc_o          (adc_o         ),
    .gen_i          (gen_i         ),
    .fb_i           (fb_i          ),
    .dac_codes_o    (dac_codes_o   ),
    .dac_rst_o      (dac_rst_o     ),
    .pdm_cfg_i      (pdm_cfg_i     ),
    .pdm_o          (pdm_o         )
  );

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  // neg slope offset binary means code = 0x1fff - sample mod 2^14
  function automatic analog_pkg::dac_code_t code_of(analog_pkg::sample_t smp);
    return 14'h1fff - 14'(smp);
  endfunction

  function automatic analog_pkg::sample_t sample_of(analog_pkg::dac_code_t code);
    logic [13:0] diff;
    diff = 14'h1fff - code;  // wraps into the signed range
    return analog_pkg::sample_t'(diff);
  endfunction

  // clip to the 14 bit signed range
  function automatic analog_pkg::sample_t saturate_sum(analog_pkg::sample_t x,
                                                       analog_pkg::sample_t y);
    int s;
    s = int'(x) + int'(y);
    if (s > 8191)
      s = 8191;
    else if (s < -8192)
      s = -8192;
    return analog_pkg::sample_t'(s[13:0]);
  endfunction

  // outputs one edge after rec was captured with loop as the level at that edge
  function automatic out_rec_t expected_outputs(in_rec_t rec, logic loop);
    out_rec_t                 res;
    analog_pkg::sample_pair_t sum;
    sum.a = saturate_sum(rec.gen.a, rec.fb.a);
    sum.b = saturate_sum(rec.gen.b, rec.fb.b);
    res.dac.a = code_of(sum.a);
    res.dac.b = code_of(sum.b);
    if (loop)
      res.adc = sum;  // dac bound samples replace the pins
    else
    begin
      res.adc.a = sample_of(rec.pins.a[15:2]);  // reserved lsbs ignored
      res.adc.b = sample_of(rec.pins.b[15:2]);
    end
    return res;
  endfunction

  // inputs that match the cleared registers with the code of zero on the pins
  function automatic in_rec_t reset_rec();
    in_rec_t rec;
    rec = '0;
    rec.pins.a = 16'h7ffc;
    rec.pins.b = 16'h7ffc;
    return rec;
  endfunction

  task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
    checks++;
    if (expected !== actual)
    begin
      errors++;
      $display("[ERROR] %s %s: expected 0x%0h, actual 0x%0h", cur_test, what, expected,
               actual);
    end
  endtask

  //////////////////////////////////////////////////
  // compare process
  //////////////////////////////////////////////////

  always @(posedge adc_clk)
  begin : compare
    in_rec_t  rec;
    out_rec_t expv;
    #2;  // outputs settled and inputs not yet moved
    if (reset_i)
    begin
      hist.delete();
      hist.push_back(reset_rec());
      hist.push_back(reset_rec());
      check_value("pdm_o in reset", 32'h0, 32'(pdm_o));
    end
    else
    begin
      rec.pins = adc_pins_i;
      rec.gen  = gen_i;
      rec.fb   = fb_i;
      hist.push_front(rec);
      if (hist.size() > 2)
        void'(hist.pop_back());
    end
    expv = expected_outputs(hist[1], digital_loop_i);
    check_value("adc_o", 32'(expv.adc), 32'(adc_o));
    check_value("dac_codes_o", 32'(expv.dac), 32'(dac_codes_o));
    check_value("dac_rst_o", 32'(reset_i), 32'(dac_rst_o));  // registered copy of reset_i
  end

  //////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////

  task automatic drive_random_inputs();
    logic [31:0] rnd;
    rnd = $random(seed);
    adc_pins_i.a = rnd[15:0];
    adc_pins_i.b = rnd[31:16];
    rnd = $random(seed);
    gen_i.a = rnd[13:0];
    fb_i.a  = rnd[29:16];
    rnd = $random(seed);
    gen_i.b = rnd[13:0];
    fb_i.b  = rnd[29:16];
  endtask

  task automatic run_random(int cycles, bit loop_random);
    logic [31:0] rnd;
    for (int i = 0; i < cycles; i++)
    begin
      @(negedge adc_clk);
      drive_random_inputs();
      if (loop_random)
      begin
        rnd = $random(seed);
        digital_loop_i = rnd[0];  // toggles mid stream
      end
    end
  endtask

  task automatic run_extremes();
    int ext_gen[8] = '{8191, -8192, 8191, -8192, 8191, -8192, 4096, 0};
    int ext_fb[8]  = '{8191, -8192, -8192, 8191, 1, -1, 4096, 0};
    for (int i = 0; i < 8; i++)
    begin
      @(negedge adc_clk);
      gen_i.a = 14'(ext_gen[i]);
      fb_i.a  = 14'(ext_fb[i]);
      gen_i.b = 14'(ext_fb[i]);  // mirrored on ch2
      fb_i.b  = 14'(ext_gen[i]);
    end
  endtask

  // returns just after the falling edge that releases reset_i
  task automatic wait_reset_release(output bit released);
    int n;
    n = 0;
    @(negedge adc_clk);
    #1;
    while (reset_i && n < 40)
    begin
      @(negedge adc_clk);
      #1;
      n++;
    end
    released = !reset_i;
  endtask

  // count ones of steady levels over one full accumulator period
  task automatic pdm_window(analog_pkg::pdm_cfg_t levels);
    int ones[analog_pkg::PDM_CHN];
    pdm_cfg_i = levels;
    repeat (2) @(negedge adc_clk);  // let the new level reach the output
    foreach (ones[i])
      ones[i] = 0;
    repeat (256)
    begin
      @(negedge adc_clk);
      for (int i = 0; i < analog_pkg::PDM_CHN; i++)
        if (pdm_o[i])
          ones[i]++;
    end
    for (int i = 0; i < analog_pkg::PDM_CHN; i++)
      check_value($sformatf("pdm_o[%0d] ones", i), 32'(levels[i]), 32'(ones[i]));
  endtask

  task automatic start_test(string name);
    cur_test        = name;
    errors_at_start = errors;
    tests_run++;
  endtask

  task automatic end_test();
    repeat (2) @(negedge adc_clk);  // drain the 2 deep pipeline
    if (errors == errors_at_start)
      $display("test %s: ok", cur_test);
    else
    begin
      tests_failed++;
      $display("test %s: %0d errors", cur_test, errors - errors_at_start);
    end
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  task automatic test_sequence();
    logic [31:0]          rnd;
    analog_pkg::pdm_cfg_t lv;
    // reset_i fell on this falling edge, the dac reset still high
    check_value("dac_rst_o as reset_i falls", 32'h1, 32'(dac_rst_o));
    @(posedge adc_clk);
    #1;
    check_value("adc_o after reset", 32'h0, 32'(adc_o));
    check_value("dac_codes_o.a after reset", 32'h1fff, 32'(dac_codes_o.a));
    check_value("dac_codes_o.b after reset", 32'h1fff, 32'(dac_codes_o.b));
    check_value("dac_rst_o after reset", 32'h0, 32'(dac_rst_o));
    check_value("pdm_o after reset", 32'h0, 32'(pdm_o));
    @(negedge adc_clk);
    pdm_cfg_i = '0;
    run_random(6, 1'b0);
    end_test();

    start_test("adc_conversion");
    run_random(200, 1'b0);
    rnd = $random(seed);
    for (int i = 0; i < 8; i++)
    begin
      @(negedge adc_clk);
      adc_pins_i.a = {rnd[13:0], 2'(i)};      // data fixed while the reserved bits move
      adc_pins_i.b = {rnd[29:16], 2'(3 - i)};
    end
    end_test();

    start_test("dac_mix_saturation");
    run_random(200, 1'b0);
    run_extremes();
    end_test();

    start_test("digital_loopback");
    @(negedge adc_clk);
    digital_loop_i = 1'b1;
    run_random(200, 1'b0);
    run_random(40, 1'b1);
    @(negedge adc_clk);
    digital_loop_i = 1'b0;
    end_test();

    start_test("pdm_density");
    lv[0] = 8'd0;
    lv[1] = 8'd1;
    lv[2] = 8'd128;
    lv[3] = 8'd255;
    pdm_window(lv);
    pdm_window({lv[0], lv[1], lv[2], lv[3]});  // reversed order
    rnd = $random(seed);
    pdm_window(rnd);
    end_test();
  endtask

  initial
  begin
    bit released;
    seed         = 32'h6dd3;
    errors       = 0;
    checks       = 0;
    tests_run    = 0;
    tests_failed = 0;
    cur_test     = "init";
    digital_loop_i = 1'b0;
    drive_random_inputs();
    pdm_cfg_i = {4{8'hff}};  // full scale while in reset

    start_test("reset_state");
    wait_reset_release(released);
    if (!released)
    begin
      $display("timeout: reset_i still high after 40 cycles");
      $display("TESTBENCH FAILED");
      $finish;
    end
    else
    begin
      test_sequence();
      $display("tests %0d, failed %0d, checks %0d, errors %0d", tests_run, tests_failed,
               checks, errors);
      if (errors == 0)
      begin
        $display("TESTBENCH PASSED");
      end
      else
      begin
        $display("TESTBENCH FAILED");
      end
      $finish;
    end
  end

endmodule : tb_analog_top

`default_nettype wire

// File: vlog.f
analog_pkg.sv
adc_frontend.sv
dac_mixer.sv
dac_formatter.sv
pdm_modulator.sv
analog_top.sv
tb_clock.sv
tb_analog_top.sv

// File: Makefile
# Verilator build and run of the analog datapath testbench

SRCS := $(shell cat vlog.f)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
obj_dir/Vtb_analog_top: vlog.f $(SRCS)
	verilator --binary --timing --timescale 1ns/100ps --top-module tb_analog_top -f vlog.f

run: obj_dir/Vtb_analog_top
	./obj_dir/Vtb_analog_top > sim.log 2>&1; cat sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
